// File: rtl/busCpuPkg.sv
package busCpuPkg;

    localparam int regCount = 16;
    localparam int regSelWidth = $clog2(regCount);   // 4 for sixteen registers

    // instruction fields, offset of each field's top bit below the word msb
    localparam int opcodeWidth = 5;
    localparam int raOffset = 5;
    localparam int rbOffset = 9;
    localparam int rdOffset = 13;
    localparam int fieldBits = 17;   // opcode plus three selects

    // opcode values as used by the existing instruction set
    typedef enum logic [4:0] {
        opAdd = 5'b00011,
        opSub = 5'b00100,
        opAnd = 5'b00101,
        opOr  = 5'b00110,
        opNop = 5'b01101,
        opMul = 5'b01111
    } aluOpE;

    typedef enum logic [3:0] {
        stIdle,
        stLoadA,   // memory data into mdr
        stLoadB,   // mdr into the selected register
        stT0,
        stT1,
        stT2,
        stT3,
        stT4,
        stT5       // mul only, upper half to hi
    } stepE;

endpackage

// File: rtl/controlBus.sv
`timescale 1ns/1ps

interface controlBus #(
    parameter int dataWidth = 32
);

    logic read;       // mdr takes the external data input
    logic mdrIn;
    logic mdrOut;
    logic irIn;
    logic yIn;
    logic zIn;
    logic zLowOut;
    logic zHighOut;
    logic hiOut;      // no supported opcode reads hi or lo back yet
    logic loOut;
    logic regIn;
    logic regOut;
    logic [busCpuPkg::regSelWidth-1:0] regSel;
    logic hiIn;
    logic loIn;
    busCpuPkg::aluOpE aluOp;

    // decoded from ir
    busCpuPkg::aluOpE opcode;
    logic [busCpuPkg::regSelWidth-1:0] ra;
    logic [busCpuPkg::regSelWidth-1:0] rb;
    logic [busCpuPkg::regSelWidth-1:0] rd;

    // the fields are packed at the top of the data word
    if (dataWidth < busCpuPkg::fieldBits) begin : gWidthCheck
        $error("controlBus: dataWidth %0d cannot hold the instruction fields", dataWidth);
    end

    modport seq (
        output read, mdrIn, mdrOut, irIn, yIn, zIn, zLowOut, zHighOut, hiOut, loOut,
        output regIn, regOut, regSel, hiIn, loIn, aluOp,
        input  opcode, ra, rb, rd
    );

    modport dp (
        input  read, mdrIn, mdrOut, irIn, yIn, zIn, zLowOut, zHighOut, hiOut, loOut,
        input  regIn, regOut, regSel, hiIn, loIn, aluOp,
        output opcode, ra, rb, rd
    );

endinterface

// File: rtl/mdrUnit.sv
`timescale 1ns/1ps

module mdrUnit #(
    parameter int dataWidth = 32
) (
    input  logic                 clock,
    input  logic                 arstN,
    controlBus.dp                ctrl,
    input  logic [dataWidth-1:0] dataIn,
    input  logic [dataWidth-1:0] busData,
    output logic [dataWidth-1:0] mdrData
);

    logic [dataWidth-1:0] mdrReg;
    logic [dataWidth-1:0] mdrNext;

    // read picks the memory side, otherwise the bus writes back
    assign mdrNext = ctrl.read ? dataIn : busData;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            mdrReg <= '0;
        end else if (ctrl.mdrIn) begin
            mdrReg <= mdrNext;
        end
    end

    assign mdrData = mdrReg;   // to the bus source mux

endmodule

// File: rtl/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer #(
    parameter int dataWidth = 32
) (
    input  logic                                clock,
    input  logic                                arstN,
    input  logic                                start,
    input  logic                                loadEn,
    input  logic [busCpuPkg::regSelWidth-1:0]   loadSel,
    controlBus.seq                              ctrl,
    output logic                                done
);

    busCpuPkg::stepE step;
    busCpuPkg::stepE stepNext;
    logic [busCpuPkg::regSelWidth-1:0] loadSelQ;
    logic isMul;
    logic writeRd;
    logic lastStep;

    // opcode and selects come from the top 17 bits of the word
    if (dataWidth < busCpuPkg::fieldBits) begin : gWidthCheck
        $error("controlSequencer: dataWidth %0d too narrow for decode", dataWidth);
    end

    assign isMul = (ctrl.opcode == busCpuPkg::opMul);
    assign writeRd = !isMul && (ctrl.opcode != busCpuPkg::opNop);   // alu ops only

    assign lastStep = (step == busCpuPkg::stLoadB)
                   || (step == busCpuPkg::stT4 && !isMul)
                   || (step == busCpuPkg::stT5);

    always_comb begin
        stepNext = step;
        case (step)
            busCpuPkg::stIdle: begin
                if (loadEn) begin
                    stepNext = busCpuPkg::stLoadA;   // load beats start
                end else if (start) begin
                    stepNext = busCpuPkg::stT0;
                end
            end
            busCpuPkg::stLoadA: stepNext = busCpuPkg::stLoadB;
            busCpuPkg::stLoadB: stepNext = busCpuPkg::stIdle;
            busCpuPkg::stT0:    stepNext = busCpuPkg::stT1;
            busCpuPkg::stT1:    stepNext = busCpuPkg::stT2;
            busCpuPkg::stT2:    stepNext = busCpuPkg::stT3;
            busCpuPkg::stT3:    stepNext = busCpuPkg::stT4;
            busCpuPkg::stT4:    stepNext = isMul ? busCpuPkg::stT5 : busCpuPkg::stIdle;
            default:            stepNext = busCpuPkg::stIdle;
        endcase
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            step <= busCpuPkg::stIdle;
            loadSelQ <= '0;
            done <= 1'b0;
        end else begin
            step <= stepNext;
            done <= lastStep;
            if (step == busCpuPkg::stIdle && loadEn) begin
                loadSelQ <= loadSel;
            end
        end
    end

    // strobes follow the current step
    always_comb begin
        ctrl.read = 1'b0;
        ctrl.mdrIn = 1'b0;
        ctrl.mdrOut = 1'b0;
        ctrl.irIn = 1'b0;
        ctrl.yIn = 1'b0;
        ctrl.zIn = 1'b0;
        ctrl.zLowOut = 1'b0;
        ctrl.zHighOut = 1'b0;
        ctrl.hiOut = 1'b0;
        ctrl.loOut = 1'b0;
        ctrl.regIn = 1'b0;
        ctrl.regOut = 1'b0;
        ctrl.regSel = '0;
        ctrl.hiIn = 1'b0;
        ctrl.loIn = 1'b0;
        ctrl.aluOp = busCpuPkg::opNop;
        case (step)
            busCpuPkg::stLoadA, busCpuPkg::stT0: begin
                ctrl.read = 1'b1;
                ctrl.mdrIn = 1'b1;
            end
            busCpuPkg::stLoadB: begin
                ctrl.mdrOut = 1'b1;
                ctrl.regIn = 1'b1;
                ctrl.regSel = loadSelQ;
            end
            busCpuPkg::stT1: begin
                ctrl.mdrOut = 1'b1;
                ctrl.irIn = 1'b1;
            end
            busCpuPkg::stT2: begin
                ctrl.regOut = 1'b1;
                ctrl.regSel = ctrl.ra;
                ctrl.yIn = 1'b1;
            end
            busCpuPkg::stT3: begin
                ctrl.regOut = 1'b1;
                ctrl.regSel = ctrl.rb;
                ctrl.zIn = 1'b1;
                ctrl.aluOp = ctrl.opcode;
            end
            busCpuPkg::stT4: begin
                ctrl.zLowOut = 1'b1;
                ctrl.regSel = ctrl.rd;
                ctrl.regIn = writeRd;   // nop writes nothing
                ctrl.loIn = isMul;
            end
            busCpuPkg::stT5: begin
                ctrl.zHighOut = 1'b1;
                ctrl.hiIn = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/aluUnit.sv
`timescale 1ns/1ps

module aluUnit #(
    parameter int dataWidth = 32
) (
    input  busCpuPkg::aluOpE         op,
    input  logic [dataWidth-1:0]     a,
    input  logic [dataWidth-1:0]     b,
    output logic [2*dataWidth-1:0]   result
);

    logic signed [2*dataWidth-1:0] aExt;
    logic signed [2*dataWidth-1:0] bExt;
    logic [2*dataWidth-1:0] product;

    // sign extended so the truncated product is the full signed result
    assign aExt = {{dataWidth{a[dataWidth-1]}}, a};
    assign bExt = {{dataWidth{b[dataWidth-1]}}, b};
    assign product = aExt * bExt;

    always_comb begin
        result = '0;   // high half stays zero for the logic and add ops
        case (op)
            busCpuPkg::opAdd: begin
                result[dataWidth-1:0] = a + b;
            end
            busCpuPkg::opSub: begin
                result[dataWidth-1:0] = a - b;
            end
            busCpuPkg::opAnd: begin
                result[dataWidth-1:0] = a & b;
            end
            busCpuPkg::opOr: begin
                result[dataWidth-1:0] = a | b;
            end
            busCpuPkg::opMul: begin
                result = product;
            end
            default: begin
                result = '0;   // nop
            end
        endcase
    end

endmodule

// File: rtl/datapathCore.sv
`timescale 1ns/1ps

module datapathCore #(
    parameter int dataWidth = 32
) (
    input  logic                 clock,
    input  logic                 arstN,
    controlBus.dp                ctrl,
    input  logic [dataWidth-1:0] mdrData,
    input  logic [dataWidth-1:0] hiData,
    input  logic [dataWidth-1:0] loData,
    output logic [dataWidth-1:0] busData
);

    logic [dataWidth-1:0] regBank [busCpuPkg::regCount];
    logic [dataWidth-1:0] yReg;
    logic [2*dataWidth-1:0] zReg;
    logic [2*dataWidth-1:0] aluResult;
    logic [dataWidth-1:0] irReg;
    logic [busCpuPkg::opcodeWidth-1:0] opField;

    // field decode from the top of ir
    assign opField = irReg[dataWidth-1 -: busCpuPkg::opcodeWidth];
    assign ctrl.ra = irReg[dataWidth-1-busCpuPkg::raOffset -: busCpuPkg::regSelWidth];
    assign ctrl.rb = irReg[dataWidth-1-busCpuPkg::rbOffset -: busCpuPkg::regSelWidth];
    assign ctrl.rd = irReg[dataWidth-1-busCpuPkg::rdOffset -: busCpuPkg::regSelWidth];

    always_comb begin
        case (opField)
            busCpuPkg::opAdd, busCpuPkg::opSub, busCpuPkg::opAnd,
            busCpuPkg::opOr, busCpuPkg::opMul: begin
                ctrl.opcode = busCpuPkg::aluOpE'(opField);
            end
            default: begin
                ctrl.opcode = busCpuPkg::opNop;   // unknown opcodes do nothing
            end
        endcase
    end

    // bus source mux, zero when nobody drives
    always_comb begin
        busData = '0;
        if (ctrl.mdrOut) begin
            busData = mdrData;
        end else if (ctrl.regOut) begin
            busData = regBank[ctrl.regSel];
        end else if (ctrl.zLowOut) begin
            busData = zReg[dataWidth-1:0];
        end else if (ctrl.zHighOut) begin
            busData = zReg[2*dataWidth-1:dataWidth];
        end else if (ctrl.hiOut) begin
            busData = hiData;
        end else if (ctrl.loOut) begin
            busData = loData;
        end
    end

    aluUnit #(
        .dataWidth(dataWidth)
    ) aluUnit_i (
        .op(ctrl.aluOp),
        .a(yReg),        // y holds the first operand
        .b(busData),
        .result(aluResult)
    );

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < busCpuPkg::regCount; i++) begin
                regBank[i] <= '0;
            end
        end else if (ctrl.regIn) begin
            regBank[ctrl.regSel] <= busData;
        end
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            yReg <= '0;
            zReg <= '0;
            irReg <= '0;
        end else begin
            if (ctrl.yIn) yReg <= busData;
            if (ctrl.zIn) zReg <= aluResult;
            if (ctrl.irIn) irReg <= busData;
        end
    end

endmodule

// File: rtl/resultStage.sv
`timescale 1ns/1ps

module resultStage #(
    parameter int dataWidth = 32
) (
    input  logic                 clock,
    input  logic                 arstN,
    controlBus.dp                ctrl,
    input  logic [dataWidth-1:0] busData,
    output logic [dataWidth-1:0] hiData,
    output logic [dataWidth-1:0] loData,
    output logic [dataWidth-1:0] resultOut
);

    logic [dataWidth-1:0] hiReg;
    logic [dataWidth-1:0] loReg;
    logic [dataWidth-1:0] resultReg;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            hiReg <= '0;
            loReg <= '0;
            resultReg <= '0;
        end else begin
            if (ctrl.hiIn) hiReg <= busData;   // upper half of a product
            if (ctrl.loIn) loReg <= busData;
            // last value written to a register or to lo
            if (ctrl.regIn || ctrl.loIn) begin
                resultReg <= busData;
            end
        end
    end

    assign hiData = hiReg;
    assign loData = loReg;
    assign resultOut = resultReg;

endmodule

// File: rtl/busCpuTop.sv
`timescale 1ns/1ps

module busCpuTop #(
    parameter int dataWidth = 32
) (
    input  logic                              clock,
    input  logic                              arstN,
    input  logic                              start,
    input  logic                              loadEn,
    input  logic [busCpuPkg::regSelWidth-1:0] loadSel,
    input  logic [dataWidth-1:0]              dataIn,
    output logic                              done,
    output logic [dataWidth-1:0]              resultOut,
    output logic [dataWidth-1:0]              hi,
    output logic [dataWidth-1:0]              lo
);

    logic [dataWidth-1:0] busData;   // shared internal bus
    logic [dataWidth-1:0] mdrData;

    controlBus #(.dataWidth(dataWidth)) ctrlBus ();

    mdrUnit #(.dataWidth(dataWidth)) mdrUnit_i (
        .clock(clock),
        .arstN(arstN),
        .ctrl(ctrlBus.dp),
        .dataIn(dataIn),
        .busData(busData),
        .mdrData(mdrData)
    );

    controlSequencer #(.dataWidth(dataWidth)) controlSequencer_i (
        .clock(clock),
        .arstN(arstN),
        .start(start),
        .loadEn(loadEn),
        .loadSel(loadSel),
        .ctrl(ctrlBus.seq),
        .done(done)
    );

    datapathCore #(.dataWidth(dataWidth)) datapathCore_i (
        .clock(clock),
        .arstN(arstN),
        .ctrl(ctrlBus.dp),
        .mdrData(mdrData),
        .hiData(hi),
        .loData(lo),
        .busData(busData)
    );

    resultStage #(.dataWidth(dataWidth)) resultStage_i (
        .clock(clock),
        .arstN(arstN),
        .ctrl(ctrlBus.dp),
        .busData(busData),
        .hiData(hi),       // also back onto the bus mux
        .loData(lo),
        .resultOut(resultOut)
    );

endmodule

// File: sim/busCpu_props.sv
`timescale 1ns/1ps

module busCpuProps (
    input logic            clock,
    input logic            arstN,
    input logic            start,
    input logic            loadEn,
    input logic            done,
    input busCpuPkg::stepE step,
    input logic [5:0]      outStrobes
);

    // bus sources are mutually exclusive
    oneBusSource: assert property (@(posedge clock) disable iff (!arstN)
        $onehot0(outStrobes))
        else $error("more than one bus source enabled");

    doneSingleCycle: assert property (@(posedge clock) disable iff (!arstN)
        done |=> !done)
        else $error("done held for two cycles");

    // mul is the longest instruction
    doneAfterStart: assert property (@(posedge clock) disable iff (!arstN)
        (step == busCpuPkg::stIdle && start && !loadEn) |-> ##[1:7] done)
        else $error("no done within 7 cycles of an accepted start");

endmodule

bind controlSequencer busCpuProps busCpuProps_i (
    .clock(clock),
    .arstN(arstN),
    .start(start),
    .loadEn(loadEn),
    .done(done),
    .step(step),
    .outStrobes({ctrl.mdrOut, ctrl.regOut, ctrl.zLowOut, ctrl.zHighOut, ctrl.hiOut, ctrl.loOut})
);

// File: sim/busCpuTb.sv
`timescale 1ns/1ps

module busCpuTb;

    localparam int dataWidth = 32;
    localparam int doneTimeout = 20;   // cycles

    logic clock;
    logic arstN;
    logic start;
    logic loadEn;
    logic [busCpuPkg::regSelWidth-1:0] loadSel;
    logic [dataWidth-1:0] dataIn;
    logic done;
    logic [dataWidth-1:0] resultOut;
    logic [dataWidth-1:0] hi;
    logic [dataWidth-1:0] lo;

    // reference model of the visible state
    logic [dataWidth-1:0] refRegs [busCpuPkg::regCount];
    logic [dataWidth-1:0] refHi;
    logic [dataWidth-1:0] refLo;
    logic [dataWidth-1:0] refResult;
    logic [15:0] lfsrState;
    int mismatchCount;
    int timeoutCount;

    busCpuTop #(.dataWidth(dataWidth)) busCpuTop_i (
        .clock(clock),
        .arstN(arstN),
        .start(start),
        .loadEn(loadEn),
        .loadSel(loadSel),
        .dataIn(dataIn),
        .done(done),
        .resultOut(resultOut),
        .hi(hi),
        .lo(lo)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic nextBit();
        logic outBit;
        logic feedback;
        outBit = lfsrState[0];
        feedback = lfsrState[0] ^ lfsrState[2] ^ lfsrState[3] ^ lfsrState[5];
        lfsrState = {feedback, lfsrState[15:1]};
        return outBit;
    endfunction

    function automatic logic [dataWidth-1:0] randWord();
        logic [dataWidth-1:0] w;
        for (int i = 0; i < dataWidth; i++) begin
            w[i] = nextBit();
        end
        return w;
    endfunction

    // opcode, ra, rb, rd packed from the msb down
    function automatic logic [dataWidth-1:0] buildInstr(input logic [4:0] op,
            input logic [3:0] ra, input logic [3:0] rb, input logic [3:0] rd);
        logic [dataWidth-1:0] w;
        w = '0;
        w[dataWidth-1 -: 5] = op;
        w[dataWidth-6 -: 4] = ra;
        w[dataWidth-10 -: 4] = rb;
        w[dataWidth-14 -: 4] = rd;
        return w;
    endfunction

    task automatic checkValue(input string what, input logic [dataWidth-1:0] got,
            input logic [dataWidth-1:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            mismatchCount++;
        end
    endtask

    task automatic checkCycles(input string what, input int got, input int exp);
        assert (got == exp) else begin
            $display("MISMATCH at %0t: %s took %0d cycles, expected %0d", $time, what, got, exp);
            mismatchCount++;
        end
    endtask

    // returns at 2 ns past the edge where done is seen
    task automatic waitDone(output int cycles);
        cycles = 0;
        do begin
            @(posedge clock);
            #2;
            cycles++;
        end while (!done && cycles < doneTimeout);
        if (!done) begin
            $display("timeout at %0t: done did not arrive within %0d cycles", $time, doneTimeout);
            timeoutCount++;
            cycles = -1;
        end
    endtask

    task automatic issue(input logic doLoad, input logic doStart, input logic [3:0] sel,
            input logic [dataWidth-1:0] data, output int cycles);
        dataIn = data;
        loadSel = sel;
        loadEn = doLoad;
        start = doStart;
        @(posedge clock);   // acceptance edge
        #2;
        loadEn = 1'b0;
        start = 1'b0;
        waitDone(cycles);
    endtask

    task automatic loadReg(input logic [3:0] sel, input logic [dataWidth-1:0] value);
        int cycles;
        issue(1'b1, 1'b0, sel, value, cycles);
        refRegs[sel] = value;
        refResult = value;
        checkCycles("load", cycles, 2);
        checkValue("resultOut after load", resultOut, refResult);
    endtask

    task automatic runOp(input logic [4:0] op, input logic [3:0] ra, input logic [3:0] rb,
            input logic [3:0] rd);
        int cycles;
        int expCycles;
        logic signed [2*dataWidth-1:0] aS;
        logic signed [2*dataWidth-1:0] bS;
        logic signed [2*dataWidth-1:0] prod;
        aS = $signed(refRegs[ra]);   // sign extended to double width
        bS = $signed(refRegs[rb]);
        prod = aS * bS;
        expCycles = 5;
        case (op)
            busCpuPkg::opAdd: refRegs[rd] = refRegs[ra] + refRegs[rb];
            busCpuPkg::opSub: refRegs[rd] = refRegs[ra] - refRegs[rb];
            busCpuPkg::opAnd: refRegs[rd] = refRegs[ra] & refRegs[rb];
            busCpuPkg::opOr:  refRegs[rd] = refRegs[ra] | refRegs[rb];
            busCpuPkg::opMul: begin
                refHi = prod[2*dataWidth-1:dataWidth];
                refLo = prod[dataWidth-1:0];
                expCycles = 6;
            end
            default: ;   // anything else is a nop
        endcase
        if (op inside {busCpuPkg::opAdd, busCpuPkg::opSub, busCpuPkg::opAnd, busCpuPkg::opOr}) begin
            refResult = refRegs[rd];
        end else if (op == busCpuPkg::opMul) begin
            refResult = refLo;
        end
        issue(1'b0, 1'b1, 4'd0, buildInstr(op, ra, rb, rd), cycles);
        checkCycles("instruction", cycles, expCycles);
        checkValue("resultOut", resultOut, refResult);
        checkValue("hi", hi, refHi);
        checkValue("lo", lo, refLo);
    endtask

    task automatic checkQuiet(input int numCycles);
        repeat (numCycles) begin
            @(posedge clock);
            #2;
            assert (!done) else begin
                $display("MISMATCH at %0t: extra done pulse", $time);
                mismatchCount++;
            end
            checkValue("resultOut while idle", resultOut, refResult);
        end
    endtask

    // start and loadEn raised during T1, both must be ignored
    task automatic busyPulses();
        int cycles;
        dataIn = buildInstr(busCpuPkg::opAdd, 4'd2, 4'd3, 4'd4);
        start = 1'b1;
        refRegs[4] = refRegs[2] + refRegs[3];
        refResult = refRegs[4];
        @(posedge clock);
        #2;
        start = 1'b0;
        @(posedge clock);   // mdr has the instruction now
        #2;
        start = 1'b1;
        loadEn = 1'b1;
        loadSel = 4'd5;
        dataIn = randWord();
        @(posedge clock);
        #2;
        start = 1'b0;
        loadEn = 1'b0;
        waitDone(cycles);
        checkCycles("busy instruction", cycles + 2, 5);
        checkValue("resultOut after busy pulses", resultOut, refResult);
        checkQuiet(8);
    endtask

    task automatic bothAtIdle();
        int cycles;
        logic [dataWidth-1:0] value;
        value = randWord();
        issue(1'b1, 1'b1, 4'd7, value, cycles);
        refRegs[7] = value;
        refResult = value;
        checkCycles("load with start", cycles, 2);
        checkValue("resultOut after load with start", resultOut, refResult);
        checkQuiet(8);
    endtask

    initial begin
        arstN = 1'b0;
        start = 1'b0;
        loadEn = 1'b0;
        loadSel = '0;
        dataIn = '0;
        lfsrState = 16'd94;
        mismatchCount = 0;
        timeoutCount = 0;
        for (int r = 0; r < busCpuPkg::regCount; r++) begin
            refRegs[r] = '0;
        end
        refHi = '0;
        refLo = '0;
        refResult = '0;
        repeat (8) @(posedge clock);
        #2;
        arstN = 1'b1;

        assert (done === 1'b0) else begin
            $display("MISMATCH at %0t: done is %b after reset", $time, done);
            mismatchCount++;
        end
        checkValue("hi after reset", hi, '0);
        checkValue("lo after reset", lo, '0);
        checkValue("resultOut after reset", resultOut, '0);

        for (int r = 1; r < busCpuPkg::regCount; r++) begin
            loadReg(4'(r), randWord());
        end
        runOp(busCpuPkg::opAdd, 4'd1, 4'd2, 4'd3);
        runOp(busCpuPkg::opSub, 4'd3, 4'd4, 4'd5);   // r3 just written
        runOp(busCpuPkg::opAnd, 4'd5, 4'd6, 4'd7);
        runOp(busCpuPkg::opOr, 4'd7, 4'd8, 4'd9);
        runOp(busCpuPkg::opSub, 4'd9, 4'd15, 4'd9);

        loadReg(4'd11, dataWidth'(5));
        loadReg(4'd12, dataWidth'(-2));
        runOp(busCpuPkg::opMul, 4'd11, 4'd12, 4'd13);
        runOp(busCpuPkg::opMul, 4'd1, 4'd2, 4'd14);

        runOp(busCpuPkg::opNop, 4'd1, 4'd2, 4'd3);
        runOp(5'b11111, 4'd4, 4'd5, 4'd6);   // undefined opcode

        busyPulses();
        bothAtIdle();
        runOp(busCpuPkg::opOr, 4'd5, 4'd5, 4'd6);   // r5 must be untouched
        runOp(busCpuPkg::opAdd, 4'd7, 4'd0, 4'd8);
        runOp(busCpuPkg::opAdd, 4'd4, 4'd8, 4'd10);

        $display("errors: %0d mismatches, %0d timeouts", mismatchCount, timeoutCount);
        if (mismatchCount == 0 && timeoutCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
rtl/busCpuPkg.sv
rtl/controlBus.sv
rtl/mdrUnit.sv
rtl/controlSequencer.sv
rtl/aluUnit.sv
rtl/datapathCore.sv
rtl/resultStage.sv
rtl/busCpuTop.sv
sim/busCpu_props.sv
sim/busCpuTb.sv
